// File: Makefile
VERILATOR   ?= verilator
TOP         := trig_tb
FLIST       := flist.f
LOG         := sim.log
COMMON_FLAGS := --timing --assert --timescale 1ns/100ps
BUILD_FLAGS := --binary $(COMMON_FLAGS)
PASS_TEXT   := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FLIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/trig_model.svh
// expected header queue, occupancy mirror and compare tasks for the trigger front end
`ifndef TRIG_MODEL_SVH
`define TRIG_MODEL_SVH

event_hdr_t  exp_q[$];       // headers in acceptance order
int          size_q[$];      // acq_size of each expected header
logic [23:0] model_trig;
logic [23:0] model_event;
logic [22:0] model_bursts;
logic [31:0] model_overflow;
logic [4:0]  pend_type;      // latched when the trigger is taken in idle
logic [23:0] pend_trig;
logic        report_pending; // readout report lands next cycle
int          report_size;
logic        acq_pending;    // acq_trigger due after the next edge
int          errors;
int          hdr_seen;
logic [43:0] last_ts;

task automatic log_failure(input string msg);
  errors++;
  $display("[FAIL] %0t: %s", $time, msg);
endtask

task automatic check_count(input logic [31:0] got, input logic [31:0] want, input string what);
  if (got !== want) log_failure($sformatf("%s got %0d expected %0d", what, got, want));
endtask

task automatic check_bursts(input logic [22:0] got, input logic [22:0] want, input string what);
  if (got !== want) log_failure($sformatf("%s got %0d expected %0d", what, got, want));
endtask

task automatic check_flag(input logic got, input logic want, input string what);
  if (got !== want) log_failure($sformatf("%s got %b expected %b", what, got, want));
endtask

task automatic check_state(input rx_state_t got, input rx_state_t want, input string what);
  if (got !== want) log_failure($sformatf("%s got %b expected %b", what, got, want));
endtask

task automatic check_hdr(input event_hdr_t got, input event_hdr_t want);
  event_hdr_t ref_hdr;
  ref_hdr = want;
  ref_hdr.timestamp = got.timestamp; // only the order of timestamps is known
  if (got !== ref_hdr) begin
    log_failure($sformatf("header got e%0b t%0d ev%0d tr%0d expected e%0b t%0d ev%0d tr%0d",
      got.empty_event, got.trig_type, got.event_num, got.trig_num,
      want.empty_event, want.trig_type, want.event_num, want.trig_num));
  end
  if (hdr_seen > 0 && got.timestamp <= last_ts) begin
    log_failure($sformatf("timestamp %0d not above previous %0d", got.timestamp, last_ts));
  end
  last_ts = got.timestamp;
endtask

// one call per cycle, at the falling edge
task automatic track_cycle();
  event_hdr_t want_hdr;
  int         size;
  int         add;
  int         sub;
  int         free;
  logic       enabled;
  logic       no_room;
  if (reset) begin
    model_trig     = 24'd1;
    model_event    = 24'd1;
    model_bursts   = '0;
    model_overflow = '0;
    report_pending = 1'b0;
    report_size    = 0;
    acq_pending    = 1'b0;
    exp_q.delete();
    size_q.delete();
  end else begin
    free = `DDR3_CAPACITY - int'(model_bursts);
    check_bursts(stored_bursts, model_bursts, "stored_bursts");
    check_count(overflow_count, model_overflow, "overflow_count");
    check_flag(ddr3_almost_full, free < `DDR3_WARN_MARGIN, "ddr3_almost_full");
    check_flag(acq_trigger, acq_pending, "acq_trigger");
    acq_pending = 1'b0;
    sub = report_pending ? report_size : 0; // report cycle, freed on next edge
    report_pending = 1'b0;
    add = 0;
    if (hdr_valid && hdr_ready) begin
      if (exp_q.size() == 0) begin
        log_failure("header arrived with no trigger waiting for it");
      end else begin
        want_hdr = exp_q.pop_front();
        size = size_q.pop_front();
        check_hdr(hdr, want_hdr);
        report_pending = !want_hdr.empty_event;
        report_size = size;
      end
      hdr_seen++;
    end
    if (state == IDLE && trigger) begin
      pend_type = trig_type;
      pend_trig = model_trig;
      model_trig++;
    end
    if (state == SEND_TRIGGER && acq_ready) begin
      size = (int'(burst_count) + 1) * int'(wfm_count) + 2;
      enabled = trig_settings[pend_type];
      no_room = free < size;
      want_hdr = '{empty_event: !(enabled && !no_room), trig_type: pend_type,
                   event_num: model_event, trig_num: pend_trig, timestamp: '0};
      exp_q.push_back(want_hdr);
      size_q.push_back(size);
      acq_pending = enabled && !no_room; // channels get the trigger
      if (enabled && !no_room) begin
        add = size;
        model_event++;
      end
      if (enabled && no_room) model_overflow++; // store full, not a disabled type
    end
    model_bursts = model_bursts + 23'(add) - 23'(sub);
    if (reset_trig_num) begin
      model_trig  = 24'd1;
      model_event = 24'd1;
    end
  end
endtask

`endif

// File: bench/trig_tb.sv
// trigger front end testbench with clock, reset, lfsr stimulus, watchdog and test phases
`include "trig_config.svh"

module trig_tb
  import trig_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_BASIC   = 20;
  localparam int N_MASK    = 40;
  localparam int N_DENSE   = 60;
  localparam int N_DDR3    = 6;
  localparam int N_RESTART = 10;
  localparam int TOTAL_TRIGGERS = N_BASIC + N_MASK + N_DENSE + N_DDR3 + N_RESTART + 1;
  localparam int WATCHDOG_CYCLES = TOTAL_TRIGGERS * 200 + 1000;

  logic        clk;
  logic        reset;
  logic        reset_trig_num;
  logic        reset_trig_timestamp;
  logic        trigger;
  logic [4:0]  trig_type;
  logic [31:0] trig_settings;
  logic [22:0] burst_count;
  logic [11:0] wfm_count;
  logic        acq_ready;
  logic        acq_trigger;
  rx_state_t   state;
  logic [22:0] stored_bursts;
  logic [31:0] overflow_count;
  logic        ddr3_almost_full;
  logic        error_trig_rate;
  logic        hdr_ready;
  logic        hdr_valid;
  event_hdr_t  hdr;
  logic [15:0] lfsr;
  int          ready_mode;  // 0 always ready, 1 random stalls, 2 held off
  int          start_count;

  `include "trig_model.svh"

  trig_top DUT (
    .clk                  (clk),
    .reset                (reset),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp),
    .trigger              (trigger),
    .trig_type            (trig_type),
    .trig_settings        (trig_settings),
    .burst_count          (burst_count),
    .wfm_count            (wfm_count),
    .acq_ready            (acq_ready),
    .acq_trigger          (acq_trigger),
    .state                (state),
    .stored_bursts        (stored_bursts),
    .overflow_count       (overflow_count),
    .ddr3_almost_full     (ddr3_almost_full),
    .error_trig_rate      (error_trig_rate),
    .hdr_ready            (hdr_ready),
    .hdr_valid            (hdr_valid),
    .hdr                  (hdr)
  );

  // fibonacci lfsr x^16+x^14+x^13+x^11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // next cycle, inputs change 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
    case (ready_mode)
      0:       hdr_ready = 1'b1;
      1:       hdr_ready = (rand_bits(3) == 32'd0); // mostly stalled
      default: hdr_ready = 1'b0;
    endcase
  endtask

  task automatic send_trigger(input logic [4:0] ttype, input bit wait_idle);
    if (wait_idle) begin
      while (state != IDLE) tick();
    end
    trigger = 1'b1;
    trig_type = ttype;
    tick();
    trigger = 1'b0;
  endtask

  // let every expected header out and the last readout settle
  task automatic drain();
    ready_mode = 0;
    while (exp_q.size() != 0 || state != IDLE) tick();
    repeat (4) tick();
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) track_cycle();

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, test sequence did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    lfsr = 16'd39;
    ready_mode = 0;
    reset = 1'b1;
    reset_trig_num = 1'b0;
    reset_trig_timestamp = 1'b0;
    trigger = 1'b0;
    trig_type = '0;
    trig_settings = '1;
    burst_count = 23'd3;  // 18 bursts per event
    wfm_count = 12'd4;
    acq_ready = 1'b1;
    hdr_ready = 1'b1;
    repeat (16) tick();
    reset = 1'b0;

    // all types enabled, no back-pressure
    start_count = hdr_seen;
    for (int i = 0; i < N_BASIC; i++) begin
      repeat (int'(rand_bits(2))) tick();
      send_trigger(5'(rand_bits(5)), 1'b1);
    end
    drain();
    check_count(32'(hdr_seen - start_count), 32'(N_BASIC), "basic header count");

    // random enable mask
    trig_settings = rand_bits(32);
    for (int i = 0; i < N_MASK; i++) send_trigger(5'(rand_bits(5)), 1'b1);
    drain();

    // dense triggers against a stalling sink
    trig_settings = '1;
    ready_mode = 1;
    for (int i = 0; i < N_DENSE; i++) begin
      repeat (int'(rand_bits(2))) tick();
      send_trigger(5'(rand_bits(5)), 1'b0);
    end
    drain();

    // three events pack the store, two more overflow
    burst_count = 23'd1397;
    wfm_count = 12'd2000;
    ready_mode = 2;
    start_count = int'(overflow_count);
    for (int i = 0; i < N_DDR3 - 1; i++) send_trigger(5'(rand_bits(5)), 1'b1);
    repeat (4) tick();
    check_flag(ddr3_almost_full, 1'b1, "almost full with store packed");
    check_count(overflow_count - 32'(start_count), 32'd2, "overflow increments");
    drain();
    send_trigger(5'(rand_bits(5)), 1'b1); // space freed by readouts
    drain();
    burst_count = 23'd3;
    wfm_count = 12'd4;

    // trigger number restart
    tick();
    reset_trig_num = 1'b1;
    tick();
    reset_trig_num = 1'b0;
    for (int i = 0; i < N_RESTART; i++) send_trigger(5'(rand_bits(5)), 1'b1);
    drain();

    // channels not ready, receiver locks in error
    acq_ready = 1'b0;
    tick();
    send_trigger(5'(rand_bits(5)), 1'b1);
    repeat (3) tick();
    check_state(state, ERROR, "state after trigger with channels busy");
    check_flag(error_trig_rate, 1'b1, "error_trig_rate");
    start_count = hdr_seen;
    repeat (40) tick();
    check_count(32'(hdr_seen - start_count), 32'd0, "headers after error");

    $display("test summary: %0d errors, %0d headers checked", errors, hdr_seen);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: design/trig_config.svh
// fifo depth, ddr3 capacity and almost-full margin defines
`ifndef TRIG_CONFIG_SVH
`define TRIG_CONFIG_SVH

// records held by the trigger information fifo
// must stay a power of two, pointers wrap naturally
`define TRIG_FIFO_DEPTH 8

// ddr3 event store size, counted in bursts
// 2^23 bursts for the full store
`define DDR3_CAPACITY 8388608

// almost-full warning fires when free bursts drop below this
`define DDR3_WARN_MARGIN 65536

`endif

// File: design/trig_info_fifo.sv
// trigger information fifo, valid/ready write side and wishbone classic read slave
`include "trig_config.svh"

module trig_info_fifo
  import trig_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  // write side from the receiver
  input  logic       info_valid,
  input  trig_info_t info,
  output logic       info_ready,

  // wishbone read slave
  input  wb_m2s_t    wb_m2s,
  output wb_s2m_t    wb_s2m
);

  localparam int DEPTH = `TRIG_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

  trig_info_t    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;  // occupancy, 0..DEPTH
  logic          ack_q;
  logic          push;
  logic          pop;
  logic          rd_req;

  assign info_ready = (count != FULL_COUNT);
  assign push       = info_valid && info_ready;
  assign pop        = ack_q; // head leaves on the ack cycle
  assign rd_req     = wb_m2s.cyc && wb_m2s.stb && !wb_m2s.we;

  // head record is on dat while ack is high
  assign wb_s2m = '{ack: ack_q, dat: mem[rd_ptr]};

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= info;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ack_q  <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;

      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // one-cycle ack, waits while empty
      ack_q <= rd_req && !ack_q && (count != '0);
    end
  end

  // an overrun would move the write pointer away from the occupancy
  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    count <= FULL_COUNT && (wr_ptr - rd_ptr) == count[AW-1:0])
    else $error("fifo pointers and occupancy disagree");

  // ack answers a live read and only with a record in store
  a_ack_not_empty: assert property (@(posedge clk) disable iff (reset)
    wb_s2m.ack |-> rd_req && count != '0)
    else $error("fifo acked a read while empty or outside a read cycle");

endmodule

// File: design/trig_pkg.sv
// trigger record, event header, wishbone bus, readout report and receiver state types
package trig_pkg;

  // receiver fsm, one-hot
  typedef enum logic [3:0] {
    IDLE            = 4'b0001,
    SEND_TRIGGER    = 4'b0010,
    STORE_TRIG_INFO = 4'b0100,
    ERROR           = 4'b1000
  } rx_state_t;

  // one entry of the trigger information fifo
  typedef struct packed {
    logic        empty_event; // no channel data for this trigger
    logic [4:0]  trig_type;
    logic [23:0] event_num;   // accepted event count
    logic [23:0] trig_num;    // every ttc trigger
    logic [43:0] timestamp;
    logic [22:0] acq_size;    // bursts written to ddr3
  } trig_info_t;

  // header sent downstream per trigger
  typedef struct packed {
    logic        empty_event;
    logic [4:0]  trig_type;
    logic [23:0] event_num;
    logic [23:0] trig_num;
    logic [43:0] timestamp;
  } event_hdr_t;

  // wishbone classic, single register slave so no address
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
  } wb_m2s_t;

  typedef struct packed {
    logic       ack;
    trig_info_t dat;
  } wb_s2m_t;

  // readout report back to the receiver
  typedef struct packed {
    logic        done;
    logic [22:0] size; // bursts freed in ddr3
  } readout_t;

endpackage

// File: design/trig_processor.sv
// trigger processor, wishbone master that turns trigger records into event headers
module trig_processor
  import trig_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  // wishbone master to the fifo
  input  wb_s2m_t    wb_s2m,
  output wb_m2s_t    wb_m2s,

  // event header stream
  input  logic       hdr_ready,
  output logic       hdr_valid,
  output event_hdr_t hdr,

  // readout report to the receiver
  output readout_t   readout
);

  typedef enum logic [1:0] {
    FETCH,   // read one record over wishbone
    PRESENT, // header offered downstream
    REPORT   // free ddr3 space of the event
  } proc_state_t;

  proc_state_t state;
  proc_state_t next_state;
  logic        req;  // drives cyc and stb together
  trig_info_t  rec;  // record being processed

  always_comb begin
    next_state = state;
    unique case (state)
      FETCH: begin
        if (wb_s2m.ack) next_state = PRESENT;
      end
      PRESENT: begin
        if (hdr_ready) begin
          // empty events never used ddr3 space
          next_state = rec.empty_event ? FETCH : REPORT;
        end
      end
      REPORT: begin
        next_state = FETCH;
      end
      default: next_state = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH;
      req   <= 1'b0;
    end else begin
      state <= next_state;
      req   <= (next_state == FETCH); // drops on the ack edge
    end
  end

  always_ff @(posedge clk) begin
    if (state == FETCH && wb_s2m.ack) rec <= wb_s2m.dat;
  end

  assign wb_m2s = '{cyc: req, stb: req, we: 1'b0};

  assign hdr_valid = (state == PRESENT);
  assign hdr = '{
    empty_event: rec.empty_event,
    trig_type:   rec.trig_type,
    event_num:   rec.event_num,
    trig_num:    rec.trig_num,
    timestamp:   rec.timestamp
  };

  // done is high for the single REPORT cycle
  assign readout = '{done: (state == REPORT), size: rec.acq_size};

  a_req_held: assert property (@(posedge clk) disable iff (reset)
    wb_m2s.cyc && wb_m2s.stb && !wb_s2m.ack |=> wb_m2s.cyc && wb_m2s.stb)
    else $error("wishbone request dropped before ack");

endmodule

// File: design/trig_top.sv
// trigger front end top, receiver feeding the fifo feeding the processor
module trig_top
  import trig_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  // ttc side
  input  logic        reset_trig_num,
  input  logic        reset_trig_timestamp,
  input  logic        trigger,
  input  logic [4:0]  trig_type,
  input  logic [31:0] trig_settings,
  input  logic [22:0] burst_count,
  input  logic [11:0] wfm_count,
  input  logic        acq_ready,
  output logic        acq_trigger,

  // status
  output rx_state_t   state,
  output logic [22:0] stored_bursts,
  output logic [31:0] overflow_count,
  output logic        ddr3_almost_full,
  output logic        error_trig_rate,

  // event header stream
  input  logic        hdr_ready,
  output logic        hdr_valid,
  output event_hdr_t  hdr
);

  logic       info_valid;
  logic       info_ready;
  trig_info_t info;
  wb_m2s_t    wb_m2s;
  wb_s2m_t    wb_s2m;
  readout_t   readout;

  ttc_trigger_receiver u_receiver (
    .clk                  (clk),
    .reset                (reset),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp),
    .trigger              (trigger),
    .trig_type            (trig_type),
    .trig_settings        (trig_settings),
    .burst_count          (burst_count),
    .wfm_count            (wfm_count),
    .acq_ready            (acq_ready),
    .acq_trigger          (acq_trigger),
    .info_ready           (info_ready),
    .info_valid           (info_valid),
    .info                 (info),
    .readout              (readout),
    .state                (state),
    .stored_bursts        (stored_bursts),
    .overflow_count       (overflow_count),
    .ddr3_almost_full     (ddr3_almost_full),
    .error_trig_rate      (error_trig_rate)
  );

  trig_info_fifo u_fifo (
    .clk        (clk),
    .reset      (reset),
    .info_valid (info_valid),
    .info       (info),
    .info_ready (info_ready),
    .wb_m2s     (wb_m2s),
    .wb_s2m     (wb_s2m)
  );

  trig_processor u_processor (
    .clk       (clk),
    .reset     (reset),
    .wb_s2m    (wb_s2m),
    .wb_m2s    (wb_m2s),
    .hdr_ready (hdr_ready),
    .hdr_valid (hdr_valid),
    .hdr       (hdr),
    .readout   (readout)
  );

endmodule

// File: design/ttc_trigger_receiver.sv
// ttc trigger receiver fsm with trigger/event counters, timestamp and ddr3 occupancy
`include "trig_config.svh"

module ttc_trigger_receiver
  import trig_pkg::*;
(
  input  logic        clk,
  input  logic        reset,

  // ttc channel b resets
  input  logic        reset_trig_num,
  input  logic        reset_trig_timestamp,

  // trigger and acquisition settings
  input  logic        trigger,       // one-cycle pulse
  input  logic [4:0]  trig_type,
  input  logic [31:0] trig_settings, // enable bit per trigger type
  input  logic [22:0] burst_count,
  input  logic [11:0] wfm_count,
  input  logic        acq_ready,     // channels can take a trigger
  output logic        acq_trigger,

  // trigger information fifo side
  input  logic        info_ready,
  output logic        info_valid,
  output trig_info_t  info,

  // readout report from the processor
  input  readout_t    readout,

  // status
  output rx_state_t   state,
  output logic [22:0] stored_bursts,
  output logic [31:0] overflow_count,
  output logic        ddr3_almost_full,
  output logic        error_trig_rate
);

  rx_state_t   next_state;
  logic [22:0] acq_size;     // bursts for one acquisition
  logic [23:0] free_bursts;  // one bit wider, capacity is 2^23
  logic        type_enabled;
  logic        ddr3_full;
  logic        accept;       // trigger goes to the channels
  logic        overflow;
  logic [22:0] add_bursts;
  logic [22:0] sub_bursts;
  logic [23:0] trig_num;     // number given to the next trigger
  logic [23:0] event_cnt;    // number given to the next accepted event
  logic [43:0] ts_cnt;       // free running cycle count

  assign acq_size = (burst_count + 23'd1) * {11'd0, wfm_count} + 23'd2;

  // occupancy checks
  assign free_bursts      = 24'(`DDR3_CAPACITY) - {1'b0, stored_bursts};
  assign ddr3_full        = free_bursts < {1'b0, acq_size};
  assign ddr3_almost_full = free_bursts < 24'(`DDR3_WARN_MARGIN);

  // type latched in idle, checked in send_trigger
  assign type_enabled = trig_settings[info.trig_type];

  assign accept   = (state == SEND_TRIGGER) && acq_ready && type_enabled && !ddr3_full;
  assign overflow = (state == SEND_TRIGGER) && acq_ready && type_enabled && ddr3_full;

  assign info_valid      = (state == STORE_TRIG_INFO);
  assign error_trig_rate = (state == ERROR);

  always_comb begin
    next_state = state;
    unique case (state)
      IDLE: begin
        if (trigger) next_state = SEND_TRIGGER;
      end
      SEND_TRIGGER: begin
        // channels still busy with the last one
        if (!acq_ready) next_state = ERROR;
        else            next_state = STORE_TRIG_INFO;
      end
      STORE_TRIG_INFO: begin
        if (info_ready) next_state = IDLE; // fifo took the record
      end
      ERROR: begin
        next_state = ERROR; // hard error, only reset leaves
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      acq_trigger <= 1'b0;
    end else begin
      state       <= next_state;
      acq_trigger <= accept; // single cycle, SEND_TRIGGER lasts one cycle
    end
  end

  // trigger and event numbering, both start at 1
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      trig_num  <= 24'd1;
      event_cnt <= 24'd1;
    end else begin
      if (state == IDLE && trigger) trig_num <= trig_num + 24'd1;
      if (accept)                   event_cnt <= event_cnt + 24'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) ts_cnt <= '0;
    else                               ts_cnt <= ts_cnt + 44'd1;
  end

  // record fields, part latched on the trigger and part on the decision
  always_ff @(posedge clk) begin
    if (state == IDLE && trigger) begin
      info.trig_type <= trig_type;
      info.trig_num  <= trig_num;
      info.timestamp <= ts_cnt;
    end
    if (state == SEND_TRIGGER) begin
      info.empty_event <= !(type_enabled && !ddr3_full);
      info.event_num   <= event_cnt; // empty events reuse the pending number
      info.acq_size    <= acq_size;
    end
  end

  // ddr3 accounting, acquisition and readout may land on the same edge
  assign add_bursts = accept ? acq_size : 23'd0;
  assign sub_bursts = readout.done ? readout.size : 23'd0;

  always_ff @(posedge clk) begin
    if (reset) begin
      stored_bursts  <= '0;
      overflow_count <= '0;
    end else begin
      stored_bursts <= stored_bursts + add_bursts - sub_bursts;
      if (overflow) overflow_count <= overflow_count + 32'd1;
    end
  end

  a_state_onehot: assert property (@(posedge clk) disable iff (reset)
    $onehot(state))
    else $error("receiver state not one-hot");

  // record must not change while the fifo holds it off
  a_info_hold: assert property (@(posedge clk) disable iff (reset)
    info_valid && !info_ready |=> info_valid && $stable(info))
    else $error("trigger record changed before fifo accepted it");

endmodule

// File: flist.f
+incdir+design
+incdir+bench
design/trig_pkg.sv
design/ttc_trigger_receiver.sv
design/trig_info_fifo.sv
design/trig_processor.sv
design/trig_top.sv
bench/trig_tb.sv
